// File: Makefile
# Verilator build and run of the L2 cache testbench

VERILATOR ?= verilator
FLAGS = --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS = --lint-only --timing --timescale 1ns/1ps
TOP = l2_cache_tb
FILELIST = l2_cache_top.f
BUILD_DIR = obj_dir
LOG = sim.log
PASS_TEXT = Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: l2_cache_top.f
+incdir+source
source/l2_cache_pkg.sv
source/l2_stage_if.sv
source/l2_cache_arb.sv
source/l2_cache_tag.sv
source/l2_cache_data.sv
source/l2_cache_smi.sv
source/l2_cache_top.sv
verif/l2_cache_chk.sv
verif/l2_cache_tb.sv

// File: source/l2_cache_arb.sv
//****************************************
// l2_cache_arb: picks a core request or
// a memory restart, restart wins
//****************************************

`include "l2_cache_macros.svh"

module l2_cache_arb
(
	input logic clk,
	input logic reset_i,
	input logic stall_pipeline_i,
	input logic pci_valid_i,
	input l2_cache_pkg::l2_request_t pci_request_i,
	output logic pci_ack_o,
	input logic smi_data_ready_i,
	input l2_cache_pkg::l2_request_t smi_request_i,
	input logic [`L2_LINE_BITS-1:0] smi_load_buffer_i,
	input logic [`L2_WAY_BITS-1:0] smi_fill_way_i,
	l2_stage_if.stage_out stage_o
);

	// core waits while the miss queue is near full or a restart goes in
	assign pci_ack_o = pci_valid_i && !stall_pipeline_i && !smi_data_ready_i;

	// lookup results belong to the tag stage
	assign stage_o.hit = 1'b0;
	assign stage_o.hit_way = '0;
	assign stage_o.fill = 1'b0;

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			stage_o.valid <= 1'b0;
			stage_o.has_sm_data <= 1'b0;
		end
		else
		begin
			stage_o.valid <= smi_data_ready_i || pci_ack_o;
			stage_o.has_sm_data <= smi_data_ready_i;
		end
	end

	always_ff @(posedge clk)
	begin
		if (smi_data_ready_i)
		begin
			stage_o.request <= smi_request_i;
			stage_o.sm_data <= smi_load_buffer_i;	// fetched line rides along
			stage_o.sm_fill_way <= smi_fill_way_i;
		end
		else
		begin
			stage_o.request <= pci_request_i;
		end
	end

endmodule

// File: source/l2_cache_data.sv
//****************************************
// l2_cache_data: line storage, byte mask
// store merge, fill write, response reg
//****************************************

`include "l2_cache_macros.svh"

module l2_cache_data
(
	input logic clk,
	input logic reset_i,
	l2_stage_if.stage_in stage_i,
	output logic response_valid_o,
	output l2_cache_pkg::l2_request_t response_request_o
);

	localparam int NUM_LINES = `L2_WAYS << `L2_SET_BITS;

	logic [`L2_LINE_BITS-1:0] line_mem [NUM_LINES];
	logic [`L2_SET_BITS+`L2_WAY_BITS-1:0] line_index;		// {set, way}
	logic [`L2_LINE_BITS-1:0] source_line;
	logic [`L2_LINE_BITS-1:0] result_line;
	logic is_store;
	logic write_line;

	assign line_index = {stage_i.request.address[`L2_SET_BITS-1:0],
		stage_i.fill ? stage_i.sm_fill_way : stage_i.hit_way};

	// fills take the fetched line, everything else the stored one
	assign source_line = stage_i.fill ? stage_i.sm_data : line_mem[line_index];
	assign is_store = stage_i.request.op == l2_cache_pkg::OP_STORE;

	// mask bit b covers byte b of the line
	always_comb
	begin
		result_line = source_line;
		if (is_store)
		begin
			for (int b = 0; b < `L2_MASK_BITS; b++)
			begin
				if (stage_i.request.mask[b])
					result_line[b*8 +: 8] = stage_i.request.data[b*8 +: 8];
			end
		end
	end

	assign write_line = stage_i.valid && (stage_i.fill || (stage_i.hit && is_store));

	always_ff @(posedge clk)
	begin
		if (write_line)
			line_mem[line_index] <= result_line;
	end

	always_ff @(posedge clk)
	begin
		if (reset_i)
			response_valid_o <= 1'b0;
		else
			response_valid_o <= stage_i.valid;
	end

	always_ff @(posedge clk)
	begin
		response_request_o <= stage_i.request;
		response_request_o.data <= result_line;		// line after any store
	end

endmodule

// File: source/l2_cache_macros.svh
//****************************************
// cache geometry and field widths
// shared by the package and all stages
//****************************************

`ifndef L2_CACHE_MACROS_SVH
`define L2_CACHE_MACROS_SVH

// request fields
`define L2_ADDR_BITS	26	// line address
`define L2_LINE_BITS	512	// one cache line
`define L2_MASK_BITS	64	// one bit per byte of a line

// organisation
`define L2_WAYS			4
`define L2_WAY_BITS		2
`define L2_SET_BITS		4	// low address bits select the set
`define L2_TAG_BITS		22	// address bits above the set index

// miss handling
`define L2_SMI_DEPTH	4	// miss queue entries

`endif

// File: source/l2_cache_pkg.sv
//****************************************
// l2_cache_pkg: opcode and sequencer
// state enums, pipeline request struct
//****************************************

`include "l2_cache_macros.svh"

package l2_cache_pkg;

	// core operations, remaining codes reserved
	typedef enum logic [2:0]
	{
		OP_LOAD = 3'd0,
		OP_STORE = 3'd1
	} l2_op_t;

	// memory interface sequencer
	typedef enum logic [1:0]
	{
		SMI_IDLE,		// waiting for a queued miss
		SMI_READ,		// line read outstanding
		SMI_RESTART		// fetched line goes back to the arbiter
	} smi_state_t;

	// one request as it travels down the pipeline
	typedef struct packed
	{
		logic [1:0] unit;
		logic [1:0] strand;
		l2_op_t op;
		logic [1:0] way;
		logic [`L2_ADDR_BITS-1:0] address;
		logic [`L2_LINE_BITS-1:0] data;
		logic [`L2_MASK_BITS-1:0] mask;
	} l2_request_t;

endpackage

// File: source/l2_cache_smi.sv
//****************************************
// l2_cache_smi: miss queue, memory read
// sequencer, restart and stall control
//****************************************

`include "l2_cache_macros.svh"

module l2_cache_smi
(
	input logic clk,
	input logic reset_i,
	input logic miss_valid_i,
	input l2_cache_pkg::l2_request_t miss_request_i,
	input logic [`L2_WAY_BITS-1:0] miss_fill_way_i,
	output logic mem_read_o,
	output logic [`L2_ADDR_BITS-1:0] mem_address_o,
	input logic mem_ready_i,
	input logic [`L2_LINE_BITS-1:0] mem_data_i,
	output logic smi_data_ready_o,
	output l2_cache_pkg::l2_request_t smi_request_o,
	output logic [`L2_LINE_BITS-1:0] smi_load_buffer_o,
	output logic [`L2_WAY_BITS-1:0] smi_fill_way_o,
	output logic stall_pipeline_o
);

	localparam int PTR_BITS = $clog2(`L2_SMI_DEPTH);
	// room for the two requests that may still be ahead of the tag stage
	localparam logic [PTR_BITS:0] STALL_LEVEL = (PTR_BITS+1)'(`L2_SMI_DEPTH - 2);

	l2_cache_pkg::l2_request_t queue_request [`L2_SMI_DEPTH];
	logic [`L2_WAY_BITS-1:0] queue_fill_way [`L2_SMI_DEPTH];
	logic [PTR_BITS-1:0] write_ptr;
	logic [PTR_BITS-1:0] read_ptr;
	logic [PTR_BITS:0] queue_count;
	l2_cache_pkg::smi_state_t state;
	logic [`L2_LINE_BITS-1:0] load_buffer;
	logic pop;

	assign pop = state == l2_cache_pkg::SMI_RESTART;		// head leaves with its restart

	assign mem_read_o = state == l2_cache_pkg::SMI_READ;
	assign mem_address_o = queue_request[read_ptr].address;	// head is stable until pop

	assign smi_data_ready_o = pop;
	assign smi_request_o = queue_request[read_ptr];
	assign smi_load_buffer_o = load_buffer;
	assign smi_fill_way_o = queue_fill_way[read_ptr];

	assign stall_pipeline_o = queue_count >= STALL_LEVEL;

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			state <= l2_cache_pkg::SMI_IDLE;
		end
		else
		begin
			case (state)
				l2_cache_pkg::SMI_IDLE:
				begin
					if (queue_count != '0)
						state <= l2_cache_pkg::SMI_READ;
				end
				l2_cache_pkg::SMI_READ:
				begin
					if (mem_ready_i)
						state <= l2_cache_pkg::SMI_RESTART;
				end
				l2_cache_pkg::SMI_RESTART:
					state <= l2_cache_pkg::SMI_IDLE;		// one restart pulse
				default:
					state <= l2_cache_pkg::SMI_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			write_ptr <= '0;
			read_ptr <= '0;
			queue_count <= '0;
		end
		else
		begin
			if (miss_valid_i)
				write_ptr <= write_ptr + 1'b1;
			if (pop)
				read_ptr <= read_ptr + 1'b1;
			if (miss_valid_i && !pop)
				queue_count <= queue_count + 1'b1;
			else if (pop && !miss_valid_i)
				queue_count <= queue_count - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (miss_valid_i)
		begin
			queue_request[write_ptr] <= miss_request_i;
			queue_fill_way[write_ptr] <= miss_fill_way_i;
		end
		if (mem_read_o && mem_ready_i)
			load_buffer <= mem_data_i;	// capture on the ready pulse
	end

endmodule

// File: source/l2_cache_tag.sv
//****************************************
// l2_cache_tag: tag and valid arrays,
// hit check, round-robin victim per set,
// tag install for restarted misses
//****************************************

`include "l2_cache_macros.svh"

module l2_cache_tag
(
	input logic clk,
	input logic reset_i,
	l2_stage_if.stage_in stage_i,
	l2_stage_if.stage_out stage_o,
	output logic miss_valid_o,
	output l2_cache_pkg::l2_request_t miss_request_o,
	output logic [`L2_WAY_BITS-1:0] miss_fill_way_o
);

	localparam int NUM_SETS = 1 << `L2_SET_BITS;

	logic [`L2_TAG_BITS-1:0] tag_mem [NUM_SETS][`L2_WAYS];
	logic [`L2_WAYS-1:0] valid_bits [NUM_SETS];
	logic [`L2_WAY_BITS-1:0] victim_way [NUM_SETS];		// next way to replace
	logic [`L2_SET_BITS-1:0] req_set;
	logic [`L2_TAG_BITS-1:0] req_tag;
	logic hit;
	logic [`L2_WAY_BITS-1:0] hit_way;
	logic install;

	assign req_set = stage_i.request.address[`L2_SET_BITS-1:0];
	assign req_tag = stage_i.request.address[`L2_ADDR_BITS-1:`L2_SET_BITS];

	always_comb
	begin
		hit = 1'b0;
		hit_way = '0;
		for (int w = 0; w < `L2_WAYS; w++)
		begin
			if (valid_bits[req_set][w] && tag_mem[req_set][w] == req_tag)
			begin
				hit = 1'b1;
				hit_way = w[`L2_WAY_BITS-1:0];
			end
		end
	end

	// a restart that hits already has its line from an earlier fill
	assign install = stage_i.valid && stage_i.has_sm_data && !hit;

	// plain misses leave the pipeline and wait in the miss queue
	assign miss_valid_o = stage_i.valid && !stage_i.has_sm_data && !hit;
	assign miss_request_o = stage_i.request;
	assign miss_fill_way_o = victim_way[req_set];

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			for (int s = 0; s < NUM_SETS; s++)
			begin
				valid_bits[s] <= '0;
				victim_way[s] <= '0;
			end
			stage_o.valid <= 1'b0;
		end
		else
		begin
			if (install)
				valid_bits[req_set][stage_i.sm_fill_way] <= 1'b1;
			if (miss_valid_o)
				victim_way[req_set] <= victim_way[req_set] + 1'b1;	// round robin
			stage_o.valid <= stage_i.valid && (hit || stage_i.has_sm_data);
		end
	end

	always_ff @(posedge clk)
	begin
		if (install)
			tag_mem[req_set][stage_i.sm_fill_way] <= req_tag;
		stage_o.request <= stage_i.request;
		stage_o.has_sm_data <= stage_i.has_sm_data;
		stage_o.sm_data <= stage_i.sm_data;
		stage_o.sm_fill_way <= stage_i.sm_fill_way;
		stage_o.hit <= hit;
		stage_o.hit_way <= hit_way;
		stage_o.fill <= install;
	end

endmodule

// File: source/l2_cache_top.sv
//****************************************
// l2_cache_top: arbiter, tag, data and
// memory interface stages with core,
// memory and response ports
//****************************************

`include "l2_cache_macros.svh"

module l2_cache_top
(
	input logic clk,
	input logic reset_i,
	input logic pci_valid_i,
	output logic pci_ack_o,
	input logic [1:0] pci_unit_i,
	input logic [1:0] pci_strand_i,
	input logic [2:0] pci_op_i,
	input logic [1:0] pci_way_i,
	input logic [`L2_ADDR_BITS-1:0] pci_address_i,
	input logic [`L2_LINE_BITS-1:0] pci_data_i,
	input logic [`L2_MASK_BITS-1:0] pci_mask_i,
	output logic mem_read_o,
	output logic [`L2_ADDR_BITS-1:0] mem_address_o,
	input logic mem_ready_i,
	input logic [`L2_LINE_BITS-1:0] mem_data_i,
	output logic response_valid_o,
	output logic [1:0] response_unit_o,
	output logic [1:0] response_strand_o,
	output logic [2:0] response_op_o,
	output logic [`L2_ADDR_BITS-1:0] response_address_o,
	output logic [`L2_LINE_BITS-1:0] response_data_o
);

	l2_cache_pkg::l2_request_t pci_request;
	l2_cache_pkg::l2_request_t response_request;
	l2_cache_pkg::l2_request_t miss_request;
	l2_cache_pkg::l2_request_t smi_request;
	logic miss_valid;
	logic [`L2_WAY_BITS-1:0] miss_fill_way;
	logic smi_data_ready;
	logic [`L2_LINE_BITS-1:0] smi_load_buffer;
	logic [`L2_WAY_BITS-1:0] smi_fill_way;
	logic stall_pipeline;

	l2_stage_if arb_to_tag();
	l2_stage_if tag_to_data();

	assign pci_request = '{
		unit: pci_unit_i,
		strand: pci_strand_i,
		op: l2_cache_pkg::l2_op_t'(pci_op_i),
		way: pci_way_i,
		address: pci_address_i,
		data: pci_data_i,
		mask: pci_mask_i
	};

	assign response_unit_o = response_request.unit;
	assign response_strand_o = response_request.strand;
	assign response_op_o = response_request.op;
	assign response_address_o = response_request.address;
	assign response_data_o = response_request.data;

	l2_cache_arb arb(.clk, .reset_i, .stall_pipeline_i(stall_pipeline), .pci_valid_i,
		.pci_request_i(pci_request), .pci_ack_o, .smi_data_ready_i(smi_data_ready),
		.smi_request_i(smi_request), .smi_load_buffer_i(smi_load_buffer),
		.smi_fill_way_i(smi_fill_way), .stage_o(arb_to_tag.stage_out));

	l2_cache_tag tag(.clk, .reset_i, .stage_i(arb_to_tag.stage_in),
		.stage_o(tag_to_data.stage_out), .miss_valid_o(miss_valid),
		.miss_request_o(miss_request), .miss_fill_way_o(miss_fill_way));

	l2_cache_data data(.clk, .reset_i, .stage_i(tag_to_data.stage_in),
		.response_valid_o, .response_request_o(response_request));

	l2_cache_smi smi(.clk, .reset_i, .miss_valid_i(miss_valid),
		.miss_request_i(miss_request), .miss_fill_way_i(miss_fill_way), .mem_read_o,
		.mem_address_o, .mem_ready_i, .mem_data_i, .smi_data_ready_o(smi_data_ready),
		.smi_request_o(smi_request), .smi_load_buffer_o(smi_load_buffer),
		.smi_fill_way_o(smi_fill_way), .stall_pipeline_o(stall_pipeline));

endmodule

// File: source/l2_stage_if.sv
//****************************************
// l2_stage_if: request bundle passed
// from one pipeline stage to the next
//****************************************

`include "l2_cache_macros.svh"

interface l2_stage_if;

	logic valid;
	l2_cache_pkg::l2_request_t request;
	logic has_sm_data;							// restart carrying a fetched line
	logic [`L2_LINE_BITS-1:0] sm_data;
	logic [`L2_WAY_BITS-1:0] sm_fill_way;
	logic hit;									// tag lookup hit
	logic [`L2_WAY_BITS-1:0] hit_way;
	logic fill;									// tag installed for this request

	modport stage_out
	(
		output valid, request, has_sm_data, sm_data, sm_fill_way,
		output hit, hit_way, fill
	);

	modport stage_in
	(
		input valid, request, has_sm_data, sm_data, sm_fill_way,
		input hit, hit_way, fill
	);

endinterface

// File: verif/l2_cache_chk.sv
//****************************************
// l2_cache_chk: core, memory and reset
// assertions, bound into l2_cache_top
//****************************************

`include "l2_cache_macros.svh"

module l2_cache_chk
(
	input logic clk,
	input logic reset_i,
	input logic pci_ack_o,
	input logic mem_read_o,
	input logic [`L2_ADDR_BITS-1:0] mem_address_o,
	input logic mem_ready_i,
	input logic response_valid_o
);

	timeunit 1ns;
	timeprecision 1ps;

	// the restart issues in the cycle after the ready pulse and wins over the core
	restart_blocks_ack: assert property (@(posedge clk) disable iff (reset_i)
		mem_read_o && mem_ready_i |=> !pci_ack_o)
		else $error("core ack granted in a restart cycle");

	// read is level held until the ready pulse
	read_held: assert property (@(posedge clk) disable iff (reset_i)
		mem_read_o && !mem_ready_i |=> mem_read_o)
		else $error("memory read dropped before ready");

	address_stable: assert property (@(posedge clk) disable iff (reset_i)
		mem_read_o && !mem_ready_i |=> $stable(mem_address_o))
		else $error("memory address changed during a read");

	reset_clears: assert property (@(posedge clk)
		reset_i |=> !response_valid_o && !mem_read_o)
		else $error("response or memory read active after reset");

endmodule

bind l2_cache_top l2_cache_chk chk0 (.clk, .reset_i, .pci_ack_o, .mem_read_o,
	.mem_address_o, .mem_ready_i, .response_valid_o);

// File: verif/l2_cache_tb.sv
//****************************************
// l2_cache_tb: clock, reset, memory model,
// LFSR, response monitor, compare tasks
// and directed tests of l2_cache_top
//****************************************

`include "l2_cache_macros.svh"

module l2_cache_tb;

	timeunit 1ns;
	timeprecision 1ps;

	typedef logic [`L2_LINE_BITS-1:0] line_t;
	typedef logic [`L2_ADDR_BITS-1:0] addr_t;

	localparam int CLK_PERIOD = 100;
	localparam int ACK_TIMEOUT = 60;		// cycles
	localparam int RESPONSE_TIMEOUT = 300;
	localparam int HIT_LATENCY = 3;
	localparam addr_t LINE_A = 26'h123451;	// set 1
	localparam addr_t LINE_B = 26'h234562;	// set 2
	localparam addr_t LINE_DUP = 26'h2AB9;	// set 9

	logic clk;
	logic reset_i;
	logic pci_valid_i;
	logic pci_ack_o;
	logic [1:0] pci_unit_i;
	logic [1:0] pci_strand_i;
	logic [2:0] pci_op_i;
	logic [1:0] pci_way_i;
	addr_t pci_address_i;
	line_t pci_data_i;
	logic [`L2_MASK_BITS-1:0] pci_mask_i;
	logic mem_read_o;
	addr_t mem_address_o;
	logic mem_ready_i = 1'b0;
	line_t mem_data_i = '0;
	logic response_valid_o;
	logic [1:0] response_unit_o;
	logic [1:0] response_strand_o;
	logic [2:0] response_op_o;
	addr_t response_address_o;
	line_t response_data_o;

	logic [16:0] lfsr_state = 17'd83559;
	int cycle_count = 0;
	int mismatch_count = 0;
	int failure_count = 0;
	bit mem_busy = 1'b0;
	int mem_delay = 0;
	addr_t read_log [$];						// addresses of memory reads, in order
	line_t shadow [addr_t];						// lines changed by stores
	l2_cache_pkg::l2_request_t seen_response;
	l2_cache_pkg::l2_request_t response_queue [$];
	int response_cycles [$];

	l2_cache_top dut0 (.*);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	always @(posedge clk)
		cycle_count <= cycle_count + 1;

	// x^17 + x^14 + 1
	function automatic logic [16:0] lfsr_step(input logic [16:0] state);
		return {state[15:0], state[16] ^ state[13]};
	endfunction

	function automatic int draw_bits(input int count);
		int value;
		value = 0;
		for (int i = 0; i < count; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			value = (value << 1) | int'(lfsr_state[0]);
		end
		return value;
	endfunction

	// word w of a line is {address, w}
	function automatic line_t memory_line(input addr_t address);
		line_t line;
		for (int w = 0; w < `L2_LINE_BITS/32; w++)
			line[w*32 +: 32] = {2'b00, address, w[3:0]};
		return line;
	endfunction

	function automatic line_t merge_store(input line_t line, input line_t data,
		input logic [`L2_MASK_BITS-1:0] mask);
		line_t merged;
		merged = line;
		for (int b = 0; b < `L2_MASK_BITS; b++)
			if (mask[b])
				merged[b*8 +: 8] = data[b*8 +: 8];
		return merged;
	endfunction

	function automatic line_t current_line(input addr_t address);
		if (shadow.exists(address))
			return shadow[address];
		return memory_line(address);
	endfunction

	function automatic l2_cache_pkg::l2_request_t make_request(input logic [1:0] unit,
		input logic [1:0] strand, input l2_cache_pkg::l2_op_t op, input addr_t address,
		input line_t data, input logic [`L2_MASK_BITS-1:0] mask);
		l2_cache_pkg::l2_request_t req;
		req = '0;
		req.unit = unit;
		req.strand = strand;
		req.op = op;
		req.address = address;
		req.data = data;
		req.mask = mask;
		return req;
	endfunction

	// memory answers after a random 1 to 8 cycles
	always @(negedge clk)
	begin
		if (mem_ready_i)
		begin
			mem_ready_i = 1'b0;
			mem_busy = 1'b0;
		end
		else if (mem_read_o && !mem_busy)
		begin
			mem_busy = 1'b1;
			mem_delay = draw_bits(3);
			read_log.push_back(mem_address_o);
		end
		else if (mem_busy && mem_delay != 0)
			mem_delay--;
		else if (mem_busy)
		begin
			mem_ready_i = 1'b1;
			mem_data_i = memory_line(mem_address_o);
		end
	end

	always @(negedge clk)
	begin
		if (response_valid_o)
		begin
			seen_response = '0;
			seen_response.unit = response_unit_o;
			seen_response.strand = response_strand_o;
			seen_response.op = l2_cache_pkg::l2_op_t'(response_op_o);
			seen_response.address = response_address_o;
			seen_response.data = response_data_o;
			response_queue.push_back(seen_response);
			response_cycles.push_back(cycle_count);
		end
	end

	task automatic compare_response(input string what, input l2_cache_pkg::l2_request_t got,
		input l2_cache_pkg::l2_request_t exp);
		if (got.unit != exp.unit || got.strand != exp.strand || got.address != exp.address
			|| got.data != exp.data)
		begin
			$display("mismatch at %0t: %s got %0d/%0d %h %h, expected %0d/%0d %h %h", $time,
				what, got.unit, got.strand, got.address, got.data, exp.unit, exp.strand,
				exp.address, exp.data);
			mismatch_count++;
		end
	endtask

	task automatic compare_op(input string what, input l2_cache_pkg::l2_op_t got,
		input l2_cache_pkg::l2_op_t exp);
		if (got != exp)
		begin
			$display("mismatch at %0t: %s op %0d, expected %s", $time, what, got, exp.name());
			mismatch_count++;
		end
	endtask

	task automatic compare_latency(input string what, input int got, input int exp);
		if (got != exp)
		begin
			$display("mismatch at %0t: %s latency %0d, expected %0d", $time, what, got, exp);
			mismatch_count++;
		end
	endtask

	task automatic compare_address(input string what, input addr_t got, input addr_t exp);
		if (got != exp)
		begin
			$display("mismatch at %0t: %s address %h, expected %h", $time, what, got, exp);
			mismatch_count++;
		end
	endtask

	// starts and returns on a falling edge
	task automatic send_request(input l2_cache_pkg::l2_request_t req, output int ack_cycle,
		output int stall_cycles);
		bit accepted;
		accepted = 1'b0;
		ack_cycle = 0;
		stall_cycles = 0;
		pci_unit_i = req.unit;
		pci_strand_i = req.strand;
		pci_op_i = req.op;
		pci_way_i = req.way;
		pci_address_i = req.address;
		pci_data_i = req.data;
		pci_mask_i = req.mask;
		pci_valid_i = 1'b1;
		while (!accepted && stall_cycles < ACK_TIMEOUT)
		begin
			#(CLK_PERIOD/4);						// mid low phase, ack settled
			accepted = pci_ack_o;
			ack_cycle = cycle_count;
			@(negedge clk);
			if (!accepted)
				stall_cycles++;
		end
		pci_valid_i = 1'b0;
		if (!accepted)
		begin
			$display("request to address %h was never acknowledged", req.address);
			failure_count++;
		end
	endtask

	task automatic wait_response(input logic [1:0] unit, input logic [1:0] strand,
		output l2_cache_pkg::l2_request_t resp, output int resp_cycle, output bit found);
		int waited;
		found = 1'b0;
		waited = 0;
		resp = '0;
		resp_cycle = 0;
		while (!found && waited < RESPONSE_TIMEOUT)
		begin
			@(posedge clk);
			for (int i = 0; i < response_queue.size(); i++)
			begin
				if (!found && response_queue[i].unit == unit
					&& response_queue[i].strand == strand)
				begin
					resp = response_queue[i];
					resp_cycle = response_cycles[i];
					response_queue.delete(i);
					response_cycles.delete(i);
					found = 1'b1;
				end
			end
			waited++;
		end
		if (!found)
		begin
			$display("no response arrived for unit %0d strand %0d", unit, strand);
			failure_count++;
		end
		@(negedge clk);
	endtask

	task automatic expect_response(input string what, input l2_cache_pkg::l2_request_t req,
		input line_t line, input int ack_cycle, input bit hit_expected);
		l2_cache_pkg::l2_request_t got;
		l2_cache_pkg::l2_request_t exp;
		int resp_cycle;
		bit found;
		exp = req;
		exp.data = line;
		wait_response(req.unit, req.strand, got, resp_cycle, found);
		if (found)
		begin
			compare_response(what, got, exp);
			compare_op(what, got.op, exp.op);
			if (hit_expected)
				compare_latency(what, resp_cycle - ack_cycle, HIT_LATENCY);
		end
	endtask

	task automatic test_load_miss_hit();
		l2_cache_pkg::l2_request_t req;
		int ack_cycle;
		int stall_cycles;
		req = make_request(2'd0, 2'd0, l2_cache_pkg::OP_LOAD, LINE_A, '0, '0);
		send_request(req, ack_cycle, stall_cycles);
		expect_response("cold load", req, current_line(LINE_A), ack_cycle, 1'b0);
		send_request(req, ack_cycle, stall_cycles);
		expect_response("load hit", req, current_line(LINE_A), ack_cycle, 1'b1);
	endtask

	task automatic test_store_merge();
		l2_cache_pkg::l2_request_t req;
		line_t merged;
		int ack_cycle;
		int stall_cycles;
		req = make_request(2'd0, 2'd1, l2_cache_pkg::OP_STORE, LINE_A,
			{8{64'h0123_4567_89AB_CDEF}}, 64'hF00F_0FF0_A5A5_0001);
		merged = merge_store(current_line(LINE_A), req.data, req.mask);
		shadow[LINE_A] = merged;
		send_request(req, ack_cycle, stall_cycles);
		expect_response("store hit", req, merged, ack_cycle, 1'b1);
		req = make_request(2'd0, 2'd2, l2_cache_pkg::OP_LOAD, LINE_A, '0, '0);
		send_request(req, ack_cycle, stall_cycles);
		expect_response("load after store", req, current_line(LINE_A), ack_cycle, 1'b1);
	endtask

	task automatic test_store_miss();
		l2_cache_pkg::l2_request_t req;
		line_t merged;
		int ack_cycle;
		int stall_cycles;
		req = make_request(2'd1, 2'd3, l2_cache_pkg::OP_STORE, LINE_B,
			{16{32'h5A5A_1234}}, 64'h8000_0000_FFFF_0F0F);
		merged = merge_store(current_line(LINE_B), req.data, req.mask);
		shadow[LINE_B] = merged;
		send_request(req, ack_cycle, stall_cycles);
		expect_response("store miss", req, merged, ack_cycle, 1'b0);
		req = make_request(2'd1, 2'd2, l2_cache_pkg::OP_LOAD, LINE_B, '0, '0);
		send_request(req, ack_cycle, stall_cycles);
		expect_response("load after store miss", req, current_line(LINE_B), ack_cycle, 1'b1);
	endtask

	// six misses to sets 3..8, issued back to back
	task automatic test_outstanding_misses();
		l2_cache_pkg::l2_request_t reqs [6];
		int ack_cycle;
		int stall_cycles;
		int stall_total;
		stall_total = 0;
		for (int i = 0; i < 6; i++)
		begin
			reqs[i] = make_request(2'(i >> 2), 2'(i), l2_cache_pkg::OP_LOAD,
				addr_t'(((100 + i) << 4) | (3 + i)), '0, '0);
			send_request(reqs[i], ack_cycle, stall_cycles);
			stall_total += stall_cycles;
		end
		for (int i = 0; i < 6; i++)
			expect_response("outstanding miss", reqs[i], current_line(reqs[i].address),
				0, 1'b0);
		if (stall_total == 0)
		begin
			$display("core ack never dropped while the miss queue filled");
			failure_count++;
		end
	endtask

	task automatic test_duplicate_misses();
		l2_cache_pkg::l2_request_t first_req;
		l2_cache_pkg::l2_request_t second_req;
		int ack_cycle;
		int stall_cycles;
		first_req = make_request(2'd3, 2'd0, l2_cache_pkg::OP_LOAD, LINE_DUP, '0, '0);
		second_req = make_request(2'd3, 2'd1, l2_cache_pkg::OP_LOAD, LINE_DUP, '0, '0);
		send_request(first_req, ack_cycle, stall_cycles);
		send_request(second_req, ack_cycle, stall_cycles);
		expect_response("first duplicate", first_req, current_line(LINE_DUP), 0, 1'b0);
		expect_response("second duplicate", second_req, current_line(LINE_DUP), 0, 1'b0);
		send_request(first_req, ack_cycle, stall_cycles);
		expect_response("load after duplicates", first_req, current_line(LINE_DUP),
			ack_cycle, 1'b1);
	endtask

	// set 12 is untouched so far, its victim counter starts at way 0
	task automatic test_victim();
		l2_cache_pkg::l2_request_t req;
		addr_t first_address;
		int ack_cycle;
		int stall_cycles;
		int reads_before;
		first_address = {22'h000300, 4'hC};
		for (int k = 0; k < 5; k++)
		begin
			req = make_request(2'd2, 2'(k), l2_cache_pkg::OP_LOAD,
				{22'h000300 + 22'(k), 4'hC}, '0, '0);
			send_request(req, ack_cycle, stall_cycles);
			expect_response("victim fill", req, current_line(req.address), 0, 1'b0);
		end
		reads_before = read_log.size();
		req = make_request(2'd2, 2'd1, l2_cache_pkg::OP_LOAD, first_address, '0, '0);
		send_request(req, ack_cycle, stall_cycles);
		expect_response("evicted line", req, current_line(first_address), 0, 1'b0);
		if (read_log.size() != reads_before + 1)
		begin
			$display("evicted line caused %0d memory reads instead of one",
				read_log.size() - reads_before);
			failure_count++;
		end
		else
			compare_address("refill read", read_log[read_log.size()-1], first_address);
	endtask

	initial
	begin
		reset_i = 1'b1;
		pci_valid_i = 1'b0;
		pci_unit_i = '0;
		pci_strand_i = '0;
		pci_op_i = '0;
		pci_way_i = '0;
		pci_address_i = '0;
		pci_data_i = '0;
		pci_mask_i = '0;
		repeat (4) @(negedge clk);
		reset_i = 1'b0;
		test_load_miss_hit();
		test_store_merge();
		test_store_miss();
		test_outstanding_misses();
		test_duplicate_misses();
		test_victim();
		$display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
		if (mismatch_count == 0 && failure_count == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule
